// ==== verilog/aurora_tx_settings.svh ====
/*
  Build-time settings for the lane transmit path. The testbench trace depends on
  the CC period and burst length, so a change here needs a new trace.
*/
`ifndef AURORA_TX_SETTINGS_SVH
`define AURORA_TX_SETTINGS_SVH

// Clock compensation schedule

// Cycles from the start of one CC burst to the start of the next
`define AURORA_CC_PERIOD 40

// CC characters sent back to back in each burst
`define AURORA_CC_LEN 3

// Idle character generation

// Start value of the idle LFSR, must not be zero
`define AURORA_IDLE_SEED 32'hACE1_2468

`endif

// ==== verilog/aurora_tx_pkg.sv ====
/*
  Lane-level types and control-character bytes. Two-bit framing fields use index
  0 for the upper half (lanes 0 and 1); lane 0 is always the most significant byte.
*/
package aurora_tx_pkg;

  // Framed word from the upstream framer, one flag of each kind per 2-byte half
  typedef struct packed {
    logic [31:0] data;
    logic [0:1]  data_v;
    logic [0:1]  pad;
    logic [0:1]  scp;
    logic [0:1]  ecp;
  } pe_word_t;

  // Idle choice for one cycle; A is only legal on lane 0
  typedef struct packed {
    logic       a;
    logic [0:3] k;
    logic [0:3] r;
  } idle_req_t;

  // Serializer word, char_is_k bit 3 goes with lane 0
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  char_is_k;
  } tx_sym_t;

  // Idle and verification characters
  localparam logic [7:0] k_char     = 8'hBC;
  localparam logic [7:0] r_char     = 8'h1C;
  localparam logic [7:0] a_char     = 8'h7C;
  localparam logic [7:0] v_char     = 8'hE8;

  // Channel PDU delimiters, first and second byte of a half
  localparam logic [7:0] scp_first  = 8'h5C;
  localparam logic [7:0] scp_second = 8'hFB;
  localparam logic [7:0] ecp_first  = 8'hFD;
  localparam logic [7:0] ecp_second = 8'hFE;

  localparam logic [7:0] pad_char   = 8'h9C;
  localparam logic [7:0] cc_char    = 8'hF7;

  // Bytes after the leading K of the SP and SPA sequences
  localparam logic [7:0] sp_tail    = 8'h4A;
  localparam logic [7:0] spa_tail   = 8'h2C;

endpackage

// ==== verilog/cc_timer.sv ====
/*
  Free-running CC scheduler with no enable and no resync. Bursts are placed at
  the end of each period, counted from the release of reset.
*/
`timescale 1ns/1ps
`include "aurora_tx_settings.svh"

module cc_timer (
  input  logic USER_CLK,
  input  logic reset,
  output logic gen_cc
);

  localparam int cnt_w = $clog2(`AURORA_CC_PERIOD);

  // Last count of a period, and first count inside the burst
  localparam logic [cnt_w-1:0] cnt_last  = cnt_w'(`AURORA_CC_PERIOD - 1);
  localparam logic [cnt_w-1:0] cnt_burst = cnt_w'(`AURORA_CC_PERIOD - `AURORA_CC_LEN);

  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] cnt_nxt;

  // Modulo-period count
  always_comb begin
    if (cnt == cnt_last) begin
      cnt_nxt = '0;
    end else begin
      cnt_nxt = cnt + 1'b1;
    end
  end

  // gen_cc follows the count it is registered with, so it is high
  // exactly while cnt sits in the burst window
  always_ff @(posedge USER_CLK) begin
    if (reset) begin
      cnt    <= '0;
      gen_cc <= 1'b0;
    end else begin
      cnt    <= cnt_nxt;
      gen_cc <= (cnt_nxt >= cnt_burst);
    end
  end

endmodule

// ==== verilog/idle_gen.sv ====
/*
  Pseudo-random idle choice from a 32-bit Galois LFSR. Each lane gets exactly
  one of K or R; A is requested for lane 0 only, about one cycle in four.
*/
`timescale 1ns/1ps
`include "aurora_tx_settings.svh"

module idle_gen (
  input  logic                    USER_CLK,
  input  logic                    reset,
  output aurora_tx_pkg::idle_req_t idle_req
);

  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic [31:0] lfsr;
  logic [31:0] lfsr_nxt;
  logic [0:3]  k_pick;
  logic        a_pick;

  always_comb begin
    lfsr_nxt = {1'b0, lfsr[31:1]} ^ ({32{lfsr[0]}} & lfsr_taps);
  end

  // Widely spaced bits so neighbouring lanes stay uncorrelated
  always_comb begin
    k_pick = {lfsr_nxt[24], lfsr_nxt[16], lfsr_nxt[8], lfsr_nxt[0]};
    a_pick = lfsr_nxt[31] & lfsr_nxt[29];
  end

  always_ff @(posedge USER_CLK) begin
    if (reset) begin
      lfsr     <= `AURORA_IDLE_SEED;
      idle_req <= '0;
    end else begin
      lfsr       <= lfsr_nxt;
      idle_req.a <= a_pick;
      // K and R are complementary per lane
      idle_req.k <= k_pick;
      idle_req.r <= ~k_pick;
    end
  end

endmodule

// ==== verilog/sym_gen_4byte.sv ====
/*
  Per-lane symbol resolution, registered once. SCP/ECP take priority over valid
  data in their half; CC silently drops any word sent during a burst.
*/
`timescale 1ns/1ps

module sym_gen_4byte (
  input  logic                     USER_CLK,
  input  logic                     reset,
  input  aurora_tx_pkg::pe_word_t  pe_word,
  input  logic                     gen_cc,
  input  logic                     gen_sp,
  input  logic                     gen_spa,
  input  logic [0:3]               gen_v,
  input  aurora_tx_pkg::idle_req_t idle_req,
  output aurora_tx_pkg::tx_sym_t   tx_sym
);

  logic [31:0] data_nxt;
  logic [3:0]  k_nxt;

  // One mux per lane, highest priority first
  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    localparam int half      = lane / 2;
    localparam bit second    = (lane % 2) == 1;
    localparam int msb       = 31 - 8 * lane;

    logic [7:0] lane_byte;

    always_comb begin
      if (gen_v[lane]) begin
        lane_byte = aurora_tx_pkg::v_char;
      end else if (gen_spa) begin
        lane_byte = (lane == 0) ? aurora_tx_pkg::k_char : aurora_tx_pkg::spa_tail;
      end else if (gen_sp) begin
        lane_byte = (lane == 0) ? aurora_tx_pkg::k_char : aurora_tx_pkg::sp_tail;
      end else if (gen_cc) begin
        lane_byte = aurora_tx_pkg::cc_char;
      end else if (pe_word.ecp[half]) begin
        lane_byte = second ? aurora_tx_pkg::ecp_second : aurora_tx_pkg::ecp_first;
      end else if (pe_word.scp[half]) begin
        lane_byte = second ? aurora_tx_pkg::scp_second : aurora_tx_pkg::scp_first;
      end else if (pe_word.data_v[half]) begin
        // Pad only ever replaces the second byte of a half
        if (second && pe_word.pad[half]) begin
          lane_byte = aurora_tx_pkg::pad_char;
        end else begin
          lane_byte = pe_word.data[msb -: 8];
        end
      end else if ((lane == 0) && idle_req.a) begin
        lane_byte = aurora_tx_pkg::a_char;
      end else if (idle_req.k[lane]) begin
        lane_byte = aurora_tx_pkg::k_char;
      end else if (idle_req.r[lane]) begin
        lane_byte = aurora_tx_pkg::r_char;
      end else begin
        // No idle choice at all, K keeps the lane aligned
        lane_byte = aurora_tx_pkg::k_char;
      end
    end
  end

  assign data_nxt = {g_lane[0].lane_byte, g_lane[1].lane_byte,
                     g_lane[2].lane_byte, g_lane[3].lane_byte};

  // K flags, lane 0 first
  // SP/SPA tails are data characters; lane 0 of SP/SPA keeps its K
  // unless that half carries data
  always_comb begin
    k_nxt[3] = ~(pe_word.data_v[0] | gen_v[0]);
    k_nxt[2] = ~((pe_word.data_v[0] & ~pe_word.pad[0]) |
                 gen_sp | gen_spa | gen_v[1]);
    k_nxt[1] = ~(pe_word.data_v[1] | gen_sp | gen_spa | gen_v[2]);
    k_nxt[0] = ~((pe_word.data_v[1] & ~pe_word.pad[1]) |
                 gen_sp | gen_spa | gen_v[3]);
  end

  always_ff @(posedge USER_CLK) begin
    if (reset) begin
      tx_sym <= '0;
    end else begin
      tx_sym.data      <= data_nxt;
      tx_sym.char_is_k <= k_nxt;
    end
  end

endmodule

// ==== verilog/aurora_tx_lane.sv ====
/*
  Transmit symbol path of one lane, one cycle from pe_word to tx_sym.
  The framer must hold off valid data while do_cc is high; no back-pressure exists.
*/
`timescale 1ns/1ps

module aurora_tx_lane (
  input  logic                    USER_CLK,
  input  logic                    reset,
  input  aurora_tx_pkg::pe_word_t pe_word,
  input  logic                    gen_sp,
  input  logic                    gen_spa,
  input  logic [0:3]              gen_v,
  output aurora_tx_pkg::tx_sym_t  tx_sym,
  output logic                    do_cc
);

  aurora_tx_pkg::idle_req_t idle_req;

  // CC request also goes out to the framer as do_cc
  cc_timer cc_timer_i (
    .USER_CLK (USER_CLK),
    .reset    (reset),
    .gen_cc   (do_cc)
  );

  idle_gen idle_gen_i (
    .USER_CLK (USER_CLK),
    .reset    (reset),
    .idle_req (idle_req)
  );

  sym_gen_4byte sym_gen_4byte_i (
    .USER_CLK (USER_CLK),
    .reset    (reset),
    .pe_word  (pe_word),
    .gen_cc   (do_cc),
    .gen_sp   (gen_sp),
    .gen_spa  (gen_spa),
    .gen_v    (gen_v),
    .idle_req (idle_req),
    .tx_sym   (tx_sym)
  );

endmodule

// ==== sim/aurora_tx_lane_sva.sv ====
/*
  Checks on the symbol generator, bound into every sym_gen_4byte instance.
*/
`timescale 1ns/1ps

module aurora_tx_lane_sva (
  input logic                    USER_CLK,
  input logic                    reset,
  input aurora_tx_pkg::pe_word_t pe_word,
  input logic                    gen_sp,
  input logic                    gen_spa,
  input logic [0:3]              gen_v,
  input aurora_tx_pkg::tx_sym_t  tx_sym
);

  // V beats every other request on its own lane
  for (genvar l = 0; l < 4; l++) begin : g_v
    a_v_lane: assert property (@(posedge USER_CLK) disable iff (reset)
      gen_v[l] |=> (tx_sym.data[31 - 8 * l -: 8] == aurora_tx_pkg::v_char) &&
                   !tx_sym.char_is_k[3 - l])
      else $error("V lane %0d not E8 with K low", l);
  end

  a_sp_word: assert property (@(posedge USER_CLK) disable iff (reset)
    (gen_sp && !gen_spa && gen_v == '0) |=>
      tx_sym.data == {aurora_tx_pkg::k_char, {3{aurora_tx_pkg::sp_tail}}})
    else $error("SP word is not BC4A4A4A");

  a_reset_zero: assert property (@(posedge USER_CLK)
    reset |=> tx_sym == '0)
    else $error("tx_sym not cleared by reset");

  // First byte of a valid half is always a data character
  a_data_k_upper: assert property (@(posedge USER_CLK) disable iff (reset)
    pe_word.data_v[0] |=> !tx_sym.char_is_k[3])
    else $error("K set on valid data in lane 0");

  a_data_k_lower: assert property (@(posedge USER_CLK) disable iff (reset)
    pe_word.data_v[1] |=> !tx_sym.char_is_k[1])
    else $error("K set on valid data in lane 2");

endmodule

bind sym_gen_4byte aurora_tx_lane_sva sva_i (
  .USER_CLK (USER_CLK),
  .reset    (reset),
  .pe_word  (pe_word),
  .gen_sp   (gen_sp),
  .gen_spa  (gen_spa),
  .gen_v    (gen_v),
  .tx_sym   (tx_sym)
);

// ==== sim/aurora_tx_lane_tb.sv ====
/*
  Trace-driven testbench for the lane transmit path; run from the project root.
  Trace rows repeat for a given number of cycles and assume a CC period of 40 and bursts of 3.
*/
`timescale 1ns/1ps

module aurora_tx_lane_tb;

  // One cycle of stimulus with the response expected after the same edge
  typedef struct packed {
    aurora_tx_pkg::pe_word_t word;
    logic                    sp;
    logic                    spa;
    logic [0:3]              v;
    aurora_tx_pkg::tx_sym_t  exp_sym;
    logic                    exp_cc;
    logic [3:0]              idle_mask;
  } cycle_t;

  localparam int max_lines   = 500;
  localparam int max_cc_wait = 60;
  localparam int next_cc_cyc = 117;

  logic                    USER_CLK;
  logic                    reset;
  aurora_tx_pkg::pe_word_t pe_word;
  logic                    gen_sp;
  logic                    gen_spa;
  logic [0:3]              gen_v;
  aurora_tx_pkg::tx_sym_t  tx_sym;
  logic                    do_cc;

  cycle_t cycles[$];
  bit     cycle_last[$];
  int     cycle_row[$];
  string  row_name[$];

  int errors;
  int row_errors;
  int tests_run;
  int tests_failed;

  aurora_tx_lane aurora_tx_lane_i (
    .USER_CLK (USER_CLK),
    .reset    (reset),
    .pe_word  (pe_word),
    .gen_sp   (gen_sp),
    .gen_spa  (gen_spa),
    .gen_v    (gen_v),
    .tx_sym   (tx_sym),
    .do_cc    (do_cc)
  );

  initial begin
    USER_CLK = 1'b0;
    forever #20 USER_CLK = ~USER_CLK;
  end

  task automatic check_value(input string sig, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, act_v);
      errors++;
      row_errors++;
    end
  endtask

  // Reads the trace and expands each row into its cycles
  task automatic load_trace(output bit ok);
    int          fd;
    int          lines;
    int          n;
    int          rep;
    string       line;
    string       nm;
    logic [31:0] f_data;
    logic [31:0] f_xd;
    logic [1:0]  f_dv;
    logic [1:0]  f_pad;
    logic [1:0]  f_scp;
    logic [1:0]  f_ecp;
    logic        f_sp;
    logic        f_spa;
    logic        f_cc;
    logic [3:0]  f_v;
    logic [3:0]  f_xk;
    logic [3:0]  f_mask;
    cycle_t      c;
    ok = 1'b1;
    lines = 0;
    fd = $fopen("sim/aurora_tx_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/aurora_tx_trace.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd) && lines < max_lines) begin
        n = $fgets(line, fd);
        lines++;
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h", nm, rep, f_data,
                    f_dv, f_pad, f_scp, f_ecp, f_sp, f_spa, f_v, f_xd, f_xk, f_cc, f_mask);
        if (n != 14 || rep < 1) begin
          $display("Malformed trace row at line %0d", lines);
          ok = 1'b0;
          continue;
        end
        c = '0;
        c.word.data        = f_data;
        c.word.data_v      = f_dv;
        c.word.pad         = f_pad;
        c.word.scp         = f_scp;
        c.word.ecp         = f_ecp;
        c.sp               = f_sp;
        c.spa              = f_spa;
        c.v                = f_v;
        c.exp_sym.data     = f_xd;
        c.exp_sym.char_is_k = f_xk;
        c.exp_cc           = f_cc;
        c.idle_mask        = f_mask;
        row_name.push_back(nm);
        for (int r = 0; r < rep; r++) begin
          cycles.push_back(c);
          cycle_row.push_back(row_name.size() - 1);
          cycle_last.push_back(r == rep - 1);
        end
      end
      if (!$feof(fd)) begin
        $display("Timed out reading the trace after %0d lines", lines);
        ok = 1'b0;
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_cycle(input cycle_t c);
    pe_word <= c.word;
    gen_sp  <= c.sp;
    gen_spa <= c.spa;
    gen_v   <= c.v;
  endtask

  // Idle-masked lanes only need a legal idle character
  task automatic check_cycle(input cycle_t c);
    logic [7:0] b;
    logic       kb;
    logic       legal;
    for (int l = 0; l < 4; l++) begin
      b  = tx_sym.data[31 - 8 * l -: 8];
      kb = tx_sym.char_is_k[3 - l];
      if (c.idle_mask[3 - l]) begin
        legal = kb && (b == aurora_tx_pkg::k_char || b == aurora_tx_pkg::r_char ||
                       (l == 0 && b == aurora_tx_pkg::a_char));
        check_value($sformatf("tx_sym lane %0d idle legal", l), 64'(1'b1), 64'(legal));
      end else begin
        check_value($sformatf("tx_sym.data lane %0d", l),
                    64'(c.exp_sym.data[31 - 8 * l -: 8]), 64'(b));
        check_value($sformatf("tx_sym.char_is_k lane %0d", l),
                    64'(c.exp_sym.char_is_k[3 - l]), 64'(kb));
      end
    end
    check_value("do_cc", 64'(c.exp_cc), 64'(do_cc));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (row_errors == 0) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s (%0d mismatches)", name, row_errors);
      tests_failed++;
    end
    row_errors = 0;
  endtask

  initial begin
    bit ok;
    int cyc;
    int waited;
    reset   = 1'b1;
    pe_word = '0;
    gen_sp  = 1'b0;
    gen_spa = 1'b0;
    gen_v   = '0;
    errors = 0;
    row_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    load_trace(ok);
    if (ok && cycles.size() == 0) begin
      $display("The trace holds no rows");
      ok = 1'b0;
    end
    if (ok) begin
      for (int i = 0; i < 5; i++) begin
        @(posedge USER_CLK);
      end
      reset <= 1'b0;
      drive_cycle(cycles[0]);
      @(negedge USER_CLK);
      check_value("tx_sym after reset", 64'(0), 64'(tx_sym));
      check_value("do_cc after reset", 64'(0), 64'(do_cc));
      finish_test("reset");
      for (int i = 0; i < cycles.size(); i++) begin
        @(posedge USER_CLK);
        if (i + 1 < cycles.size()) begin
          drive_cycle(cycles[i + 1]);
        end else begin
          drive_cycle('0);
        end
        @(negedge USER_CLK);
        check_cycle(cycles[i]);
        if (cycle_last[i]) begin
          finish_test(row_name[cycle_row[i]]);
        end
      end
      // The schedule keeps running after the trace ends
      cyc = cycles.size();
      waited = 0;
      while (do_cc !== 1'b1 && waited < max_cc_wait) begin
        @(posedge USER_CLK);
        @(negedge USER_CLK);
        cyc++;
        waited++;
      end
      if (do_cc !== 1'b1) begin
        $display("Timed out waiting for the next CC burst");
        ok = 1'b0;
      end else begin
        check_value("cycle of next do_cc", 64'(next_cc_cyc), 64'(cyc));
        finish_test("cc_next_burst");
      end
    end
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (ok && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/aurora_tx_trace.txt ====
# name rep data data_v pad scp ecp sp spa v | exp_data exp_k exp_do_cc idle_mask (hex)
# 2/4-bit fields: MSB is the upper half or lane 0; rep is a decimal cycle count
idle_start 4 00000000 0 0 0 0 0 0 0 00000000 0 0 F
data_pass 1 11223344 3 0 0 0 0 0 0 11223344 0 0 0
data_pad 1 AABBCCDD 3 3 0 0 0 0 0 AA9CCC9C 5 0 0
data_upper 1 01020304 2 0 0 0 0 0 0 01020000 0 0 3
scp_both 1 00000000 0 0 3 0 0 0 0 5CFB5CFB F 0 0
ecp_both 1 00000000 0 0 0 3 0 0 0 FDFEFDFE F 0 0
ecp_over_scp 1 00000000 0 0 3 2 0 0 0 FDFE5CFB F 0 0
data_ecp 1 55660000 2 0 0 1 0 0 0 5566FDFE 3 0 0
scp_pad 1 00007788 1 1 2 0 0 0 0 5CFB779C D 0 0
sp_word 1 00000000 0 0 0 0 1 0 0 BC4A4A4A 8 0 0
spa_word 1 00000000 0 0 0 0 0 1 0 BC2C2C2C 8 0 0
spa_over_sp 1 00000000 0 0 0 0 1 1 0 BC2C2C2C 8 0 0
v_all 1 DEADBEEF 3 0 0 0 1 0 F E8E8E8E8 0 0 0
v_lane1_scp 1 00000000 0 0 3 0 0 0 4 5CE85CFB B 0 0
v_lane3_sp 1 00000000 0 0 0 0 1 0 1 BC4A4AE8 8 0 0
v_lane0_idle 1 00000000 0 0 0 0 0 0 8 E8000000 0 0 7
idle_run 17 00000000 0 0 0 0 0 0 0 00000000 0 0 F
cc_warn 1 00000000 0 0 0 0 0 0 0 00000000 0 1 F
cc_over_scp 2 00000000 0 0 3 0 0 0 0 F7F7F7F7 F 1 0
cc_end 1 00000000 0 0 0 0 0 0 0 F7F7F7F7 F 0 0
idle_gap 36 00000000 0 0 0 0 0 0 0 00000000 0 0 F
cc_warn2 1 00000000 0 0 0 0 0 0 0 00000000 0 1 F
sp_over_cc 1 00000000 0 0 0 0 1 0 0 BC4A4A4A 8 1 0
spa_v_over_cc 1 00000000 0 0 0 0 0 1 2 BC2CE82C 8 1 0
cc_v_lane3 1 00000000 0 0 0 0 0 0 1 F7F7F7E8 E 0 0
idle_end 3 00000000 0 0 0 0 0 0 0 00000000 0 0 F

// ==== flist.f ====
+incdir+verilog
verilog/aurora_tx_pkg.sv
verilog/cc_timer.sv
verilog/idle_gen.sv
verilog/sym_gen_4byte.sv
verilog/aurora_tx_lane.sv
sim/aurora_tx_lane_sva.sv
sim/aurora_tx_lane_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the lane testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aurora_tx_lane_tb \
  -f flist.f -o aurora_tx_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/aurora_tx_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
